// ==== Makefile ====
# verilator flow for the reduced mips core
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_lite.f
OBJ_DIR   ?= obj_dir
# extra elaboration options, for example SEED_ARGS=-GSEED=12345
SEED_ARGS ?=
VFLAGS    ?= -Wno-fatal
PASS_TEXT := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) $(SEED_ARGS)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/mips_checker.sv ====
//**********************************************************************
// instruction-level reference model of the reduced mips core
// samples the dut on the falling edge, after the memory paths settle
// models the kept subset only, anything else is treated as a halt
// data memory model covers the 64 words at address 0
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module mips_checker import mips_pkg::*; (
   input  logic       clk,
   input  logic       rst_b,
   input  word_addr_t inst_addr,
   input  word_t      inst,
   input  word_addr_t mem_addr,
   input  word_t      mem_data_in,
   input  logic       mem_we,
   input  logic       halted,
   output int         errors
);

   word_t regs [`MIPS_NUM_REGS];
   word_t dmem [64];
   // model pc and halt state
   word_t pc;
   logic  m_halted;
   int    err_count = 0;

   assign errors = err_count;

   task automatic expect_equal(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         err_count++;
         $display("[ERROR] %0t %s expected %08h got %08h", $time, name, exp, got);
      end
   endtask

   // executes the instruction on inst and checks the data port
   task automatic retire;
      logic [5:0] op;
      logic [5:0] fn;
      logic [4:0] sh;
      reg_idx_t   widx;
      word_t      a;
      word_t      b;
      word_t      simm;
      word_t      zimm;
      word_t      addr;
      word_t      next_pc;
      word_t      wval;
      logic       wr;
      logic       is_store;
      logic       stop;
      op       = inst[31:26];
      fn       = inst[5:0];
      sh       = inst[10:6];
      a        = regs[inst[25:21]];
      b        = regs[inst[20:16]];
      simm     = {{16{inst[15]}}, inst[15:0]};
      zimm     = {16'h0000, inst[15:0]};
      addr     = a + simm;
      next_pc  = pc + 32'd4;
      // most instructions write rt
      widx     = inst[20:16];
      wval     = '0;
      wr       = 1'b1;
      is_store = 1'b0;
      stop     = 1'b0;
      case (op)
         `MIPS_OP_SPECIAL:
         begin
            widx = inst[15:11];
            case (fn)
               `MIPS_FN_ADDU: wval = a + b;
               `MIPS_FN_SUBU: wval = a - b;
               `MIPS_FN_AND: wval = a & b;
               `MIPS_FN_OR: wval = a | b;
               `MIPS_FN_XOR: wval = a ^ b;
               `MIPS_FN_NOR: wval = ~(a | b);
               `MIPS_FN_SLT: wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               `MIPS_FN_SLL: wval = b << sh;
               `MIPS_FN_SRL: wval = b >> sh;
               `MIPS_FN_SRA: wval = $signed(b) >>> sh;
               `MIPS_FN_JR:
               begin
                  wr      = 1'b0;
                  next_pc = a;
               end
               default:
               begin
                  // syscall, or a reserved funct
                  wr   = 1'b0;
                  stop = 1'b1;
               end
            endcase
         end
         `MIPS_OP_ADDIU: wval = a + simm;
         `MIPS_OP_SLTI: wval = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
         `MIPS_OP_ANDI: wval = a & zimm;
         `MIPS_OP_ORI: wval = a | zimm;
         `MIPS_OP_XORI: wval = a ^ zimm;
         `MIPS_OP_LUI: wval = {inst[15:0], 16'h0000};
         `MIPS_OP_LW: wval = dmem[addr[7:2]];
         `MIPS_OP_SW:
         begin
            wr       = 1'b0;
            is_store = 1'b1;
         end
         `MIPS_OP_BEQ, `MIPS_OP_BNE:
         begin
            wr = 1'b0;
            // beq wants equal operands, bne unequal ones
            if ((a == b) == (op == `MIPS_OP_BEQ))
               next_pc = pc + 32'd4 + (simm << 2);
         end
         `MIPS_OP_J, `MIPS_OP_JAL:
         begin
            wr      = (op == `MIPS_OP_JAL);
            widx    = 5'd31;
            // link is the next instruction, no delay slot
            wval    = pc + 32'd4;
            next_pc = {pc[31:28], inst[25:0], 2'b00};
         end
         default:
         begin
            wr   = 1'b0;
            stop = 1'b1;
         end
      endcase
      expect_equal("mem_we", 32'(mem_we), 32'(is_store));
      if (is_store)
      begin
         expect_equal("mem_addr", 32'(mem_addr), 32'(addr[31:2]));
         expect_equal("mem_data_in", mem_data_in, b);
         dmem[addr[7:2]] = b;
      end
      // register 0 keeps its zero
      if (wr && widx != 5'd0)
         regs[widx] = wval;
      if (stop)
         m_halted = 1'b1;
      else
         pc = next_pc;
   endtask

   always @(negedge clk)
   begin
      if (!rst_b)
      begin
         pc       = `MIPS_TEXT_START;
         m_halted = 1'b0;
         for (int k = 0; k < `MIPS_NUM_REGS; k++)
         begin
            regs[k] = '0;
         end
         for (int k = 0; k < 64; k++)
         begin
            dmem[k] = '0;
         end
      end
      else
      begin
         // fetch address follows the model pc, frozen once halted
         expect_equal("inst_addr", 32'(inst_addr), pc >> 2);
         expect_equal("halted", 32'(halted), 32'(m_halted));
         if (m_halted)
            expect_equal("mem_we", 32'(mem_we), 32'd0);
         else
            retire();
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_mips_core.sv ====
//**********************************************************************
// testbench of the reduced mips core
// random program from a fixed lcg seed, control flow only goes forward
// so every run ends on the closing syscall
// instruction memory holds 200 words, data memory 64 words at address 0
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module tb_mips_core import mips_pkg::*; #(
   parameter word_t SEED = 32'h9571_8ef3
) ();

   localparam int PROG_LEN     = 200;
   localparam int RESET_CYCLES = 5;
   localparam int CYCLE_LIMIT  = PROG_LEN + RESET_CYCLES + 50;
   localparam int DMEM_WORDS   = 64;
   // jr addresses are built in this register, random code never writes it
   localparam int JR_REG       = 30;
   localparam word_addr_t START_WORD = word_addr_t'(`MIPS_TEXT_START >> 2);

   logic       clk;
   logic       rst_b;
   word_t      inst;
   word_t      mem_data_out;
   word_addr_t inst_addr;
   word_addr_t mem_addr;
   word_t      mem_data_in;
   logic       mem_we;
   logic       halted;
   int         errors;
   word_addr_t imem_idx;
   word_t      imem [PROG_LEN];
   word_t      dmem [DMEM_WORDS];
   bit         is_target [PROG_LEN];
   word_t      lcg_state;
   int         cycles;
   bit         timed_out;

   // 8 ns period
   always #4 clk = ~clk;

   // memories answer within the cycle
   assign imem_idx     = inst_addr - START_WORD;
   // outside the program a reserved word halts the core
   assign inst         = (imem_idx < word_addr_t'(PROG_LEN)) ? imem[imem_idx[7:0]] : 32'hffff_ffff;
   assign mem_data_out = dmem[mem_addr[5:0]];

   // cleared while reset is held, written on store cycles
   always @(posedge clk)
   begin
      if (!rst_b)
      begin
         for (int k = 0; k < DMEM_WORDS; k++)
         begin
            dmem[k] <= '0;
         end
      end
      else if (mem_we)
         dmem[mem_addr[5:0]] <= mem_data_in;
   end

   mips_core i_mips_core (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst         (inst),
      .mem_data_out (mem_data_out),
      .inst_addr    (inst_addr),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_we       (mem_we),
      .halted       (halted)
   );

   mips_checker i_mips_checker (
      .clk         (clk),
      .rst_b       (rst_b),
      .inst_addr   (inst_addr),
      .inst        (inst),
      .mem_addr    (mem_addr),
      .mem_data_in (mem_data_in),
      .mem_we      (mem_we),
      .halted      (halted),
      .errors      (errors)
   );

   function automatic word_t lcg_next(input word_t s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // next random value below bound
   task automatic draw(input int bound, output int val);
      lcg_state = lcg_next(lcg_state);
      val = int'(lcg_state[30:8]) % bound;
   endtask

   function automatic word_t rtype_word(input logic [5:0] fn, input int rs, input int rt,
                                        input int rd, input int sh);
      return {`MIPS_OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
   endfunction

   function automatic word_t itype_word(input logic [5:0] op, input int rs, input int rt,
                                        input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   // absolute jump to program slot idx
   function automatic word_t jtype_word(input logic [5:0] op, input int idx);
      return {op, 26'(START_WORD) + 26'(idx)};
   endfunction

   function automatic logic [5:0] alu_funct(input int sel);
      case (sel)
         0: return `MIPS_FN_ADDU;
         1: return `MIPS_FN_SUBU;
         2: return `MIPS_FN_AND;
         3: return `MIPS_FN_OR;
         4: return `MIPS_FN_XOR;
         5: return `MIPS_FN_NOR;
         6: return `MIPS_FN_SLT;
         7: return `MIPS_FN_SLL;
         8: return `MIPS_FN_SRL;
         default: return `MIPS_FN_SRA;
      endcase
   endfunction

   function automatic logic [5:0] imm_opcode(input int sel);
      case (sel)
         0: return `MIPS_OP_ADDIU;
         1: return `MIPS_OP_SLTI;
         2: return `MIPS_OP_ANDI;
         3: return `MIPS_OP_ORI;
         4: return `MIPS_OP_XORI;
         default: return `MIPS_OP_LUI;
      endcase
   endfunction

   task automatic fill_program;
      int i;
      int kind;
      int sel;
      int r1;
      int r2;
      int r3;
      int v;
      int tgt;
      i = 0;
      for (int k = 0; k < PROG_LEN; k++)
      begin
         is_target[k] = 1'b0;
      end
      while (i < PROG_LEN - 1)
      begin
         draw(16, kind);
         draw(10, sel);
         // destinations stay clear of the jr register and ra
         draw(30, r1);
         draw(32, r2);
         draw(32, r3);
         draw(65536, v);
         draw(8, tgt);
         // forward target 1 to 8 slots ahead, never past the syscall
         tgt = i + 1 + tgt;
         if (tgt > PROG_LEN - 1)
            tgt = PROG_LEN - 1;
         if (kind < 5)
            imem[i] = rtype_word(alu_funct(sel), r2, r3, r1, v % 32);
         else if (kind < 9)
            imem[i] = itype_word(imm_opcode(sel % 6), r2, r1, v);
         else if (kind == 9)
            imem[i] = itype_word(`MIPS_OP_LW, 0, r1, (v % DMEM_WORDS) * 4);
         else if (kind < 12)
            imem[i] = itype_word(`MIPS_OP_SW, 0, r3, (v % DMEM_WORDS) * 4);
         else if (kind == 12)
         begin
            imem[i] = itype_word(sel[0] ? `MIPS_OP_BNE : `MIPS_OP_BEQ, r2, r3, tgt - i - 1);
            is_target[tgt] = 1'b1;
         end
         else if (kind == 13)
         begin
            imem[i] = jtype_word(sel[0] ? `MIPS_OP_JAL : `MIPS_OP_J, tgt);
            is_target[tgt] = 1'b1;
         end
         else if (i <= PROG_LEN - 4 && !is_target[i + 1] && !is_target[i + 2])
         begin
            // lui/ori/jr group, entered only from its first word
            tgt = (tgt + 2 > PROG_LEN - 1) ? PROG_LEN - 1 : tgt + 2;
            imem[i]     = itype_word(`MIPS_OP_LUI, 0, JR_REG, `MIPS_TEXT_START >> 16);
            // low half of the text base is zero
            imem[i + 1] = itype_word(`MIPS_OP_ORI, JR_REG, JR_REG, tgt * 4);
            imem[i + 2] = rtype_word(`MIPS_FN_JR, JR_REG, 0, 0, 0);
            is_target[tgt] = 1'b1;
            i = i + 2;
         end
         else
            imem[i] = itype_word(`MIPS_OP_ADDIU, r2, r1, v);
         i++;
      end
      imem[PROG_LEN - 1] = rtype_word(`MIPS_FN_SYSCALL, 0, 0, 0, 0);
   endtask

   initial
   begin
      clk       = 1'b0;
      rst_b     = 1'b0;
      timed_out = 1'b0;
      lcg_state = SEED;
      fill_program();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_b  = 1'b1;
      cycles = RESET_CYCLES;
      while (!halted && cycles < CYCLE_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!halted)
      begin
         timed_out = 1'b1;
         $display("timeout, core still running after %0d cycles", cycles);
      end
      else
      begin
         // halted state must hold for a while
         repeat (8) @(negedge clk);
      end
      // let the checks of the last falling edge land in the count
      @(posedge clk);
      $display("run done, %0d check errors, %0d timeouts", errors, timed_out);
      if (errors == 0 && !timed_out)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/mips_alu.sv ====
//********************************************************************
// integer alu of the reduced core
// shifts take their amount from the shamt field only
// no overflow traps, add and sub wrap
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mips_alu import mips_pkg::*; (
   input  alu_op_e    op,
   input  word_t      a,
   input  word_t      b,
   input  logic [4:0] shamt,
   output word_t      result
);

   always_comb
   begin
      case (op)
         ALU_ADD: result = a + b;
         ALU_SUB: result = a - b;
         ALU_AND: result = a & b;
         ALU_OR: result = a | b;
         ALU_XOR: result = a ^ b;
         ALU_NOR: result = ~(a | b);
         // signed compare, result is 0 or 1
         ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
         // shifts act on the rt operand
         ALU_SLL: result = b << shamt;
         ALU_SRL: result = b >> shamt;
         ALU_SRA: result = $signed(b) >>> shamt;
         // immediate into the upper half, low half cleared
         ALU_LUI: result = {b[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/mips_core.sv ====
//********************************************************************
// single-cycle core for a reduced mips integer subset
// instruction and data memories must answer within the same cycle
// word accesses only, mem_we is a single strobe for a full word
// jal links pc+4
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; (
   input  logic       clk,
   input  logic       rst_b,
   input  word_t      inst,
   input  word_t      mem_data_out,
   output word_addr_t inst_addr,
   output word_addr_t mem_addr,
   output word_t      mem_data_in,
   output logic       mem_we,
   output logic       halted
);

   alu_op_e  alu_op;
   logic     alu_use_imm;
   word_t    imm;
   reg_idx_t rs;
   reg_idx_t rt;
   logic     reg_we;
   reg_idx_t wr_idx;
   wb_sel_e  wb_sel;
   pc_sel_e  pc_sel;
   logic     branch_ne;
   logic     store;
   logic     halt_req;
   word_t    rs_data;
   word_t    rt_data;
   word_t    alu_b;
   word_t    alu_result;
   word_t    wb_data;
   word_t    pc;
   word_t    pc_plus4;

   // fetch, word address of the current pc
   assign inst_addr = pc[31:2];

   mips_decode i_mips_decode (
      .inst        (inst),
      .alu_op      (alu_op),
      .alu_use_imm (alu_use_imm),
      .imm         (imm),
      .rs          (rs),
      .rt          (rt),
      .rd          (),
      .reg_we      (reg_we),
      .wr_idx      (wr_idx),
      .wb_sel      (wb_sel),
      .pc_sel      (pc_sel),
      .branch_ne   (branch_ne),
      .store       (store),
      .halt_req    (halt_req)
   );

   // no state changes once halted
   mips_regfile i_mips_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (rs),
      .rt_idx  (rt),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .we      (reg_we && !halted),
      .wr_idx  (wr_idx),
      .wr_data (wb_data)
   );

   // second operand is rt or the extended immediate
   assign alu_b = alu_use_imm ? imm : rt_data;

   mips_alu i_mips_alu (
      .op     (alu_op),
      .a      (rs_data),
      .b      (alu_b),
      .shamt  (inst[10:6]),
      .result (alu_result)
   );

   mips_pc_unit i_mips_pc_unit (
      .clk       (clk),
      .rst_b     (rst_b),
      .pc_sel    (pc_sel),
      .branch_ne (branch_ne),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .imm       (imm),
      .target    (inst[25:0]),
      .halt_req  (halt_req),
      .pc        (pc),
      .pc_plus4  (pc_plus4),
      .halted    (halted)
   );

   // write-back source
   always_comb
   begin
      case (wb_sel)
         WB_LOAD: wb_data = mem_data_out;
         WB_LINK: wb_data = pc_plus4;
         default: wb_data = alu_result;
      endcase
   end

   // data port, address from base plus offset
   assign mem_addr    = alu_result[31:2];
   assign mem_data_in = rt_data;
   assign mem_we      = store && !halted;

endmodule

`default_nettype wire

// ==== design/mips_decode.sv ====
//********************************************************************
// instruction decoder, purely combinational
// anything outside the kept subset, and syscall, asks for a halt
// and leaves every write strobe low
//********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module mips_decode import mips_pkg::*; (
   input  word_t    inst,
   output alu_op_e  alu_op,
   output logic     alu_use_imm,
   output word_t    imm,
   output reg_idx_t rs,
   output reg_idx_t rt,
   output reg_idx_t rd,
   output logic     reg_we,
   output reg_idx_t wr_idx,
   output wb_sel_e  wb_sel,
   output pc_sel_e  pc_sel,
   output logic     branch_ne,
   output logic     store,
   output logic     halt_req
);

   // jal links into ra
   localparam reg_idx_t LINK_REG = 5'd31;

   logic [5:0] op;
   logic [5:0] funct;
   imm16_t     imm_f;
   logic       known;
   logic       is_special;
   logic       is_jr;
   logic       is_syscall;
   logic       is_imm_alu;
   logic       is_lw;
   logic       is_sw;
   logic       is_jal;
   logic       is_jump;
   logic       is_branch;
   logic       zero_ext;

   // instruction fields
   assign op    = inst[31:26];
   assign funct = inst[5:0];
   assign rs    = inst[25:21];
   assign rt    = inst[20:16];
   assign rd    = inst[15:11];
   assign imm_f = inst[15:0];

   // alu operation, and whether the encoding is one we implement
   always_comb
   begin
      alu_op = ALU_ADD;
      known  = 1'b1;
      if (op == `MIPS_OP_SPECIAL)
      begin
         case (funct)
            `MIPS_FN_SLL: alu_op = ALU_SLL;
            `MIPS_FN_SRL: alu_op = ALU_SRL;
            `MIPS_FN_SRA: alu_op = ALU_SRA;
            `MIPS_FN_ADDU: alu_op = ALU_ADD;
            `MIPS_FN_SUBU: alu_op = ALU_SUB;
            `MIPS_FN_AND: alu_op = ALU_AND;
            `MIPS_FN_OR: alu_op = ALU_OR;
            `MIPS_FN_XOR: alu_op = ALU_XOR;
            `MIPS_FN_NOR: alu_op = ALU_NOR;
            `MIPS_FN_SLT: alu_op = ALU_SLT;
            // no alu result needed, add is a harmless default
            `MIPS_FN_JR, `MIPS_FN_SYSCALL: alu_op = ALU_ADD;
            default: known = 1'b0;
         endcase
      end
      else
      begin
         case (op)
            `MIPS_OP_SLTI: alu_op = ALU_SLT;
            `MIPS_OP_ANDI: alu_op = ALU_AND;
            `MIPS_OP_ORI: alu_op = ALU_OR;
            `MIPS_OP_XORI: alu_op = ALU_XOR;
            `MIPS_OP_LUI: alu_op = ALU_LUI;
            // lw/sw use the adder for base plus offset
            `MIPS_OP_ADDIU, `MIPS_OP_LW, `MIPS_OP_SW: alu_op = ALU_ADD;
            `MIPS_OP_J, `MIPS_OP_JAL, `MIPS_OP_BEQ, `MIPS_OP_BNE: alu_op = ALU_ADD;
            default: known = 1'b0;
         endcase
      end
   end

   // instruction classes
   assign is_special = (op == `MIPS_OP_SPECIAL);
   assign is_jr      = is_special && (funct == `MIPS_FN_JR);
   assign is_syscall = is_special && (funct == `MIPS_FN_SYSCALL);
   assign is_imm_alu = op inside {`MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_ANDI,
                                  `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI};
   assign is_lw      = (op == `MIPS_OP_LW);
   assign is_sw      = (op == `MIPS_OP_SW);
   assign is_jal     = (op == `MIPS_OP_JAL);
   assign is_jump    = (op == `MIPS_OP_J) || is_jal;
   assign is_branch  = (op == `MIPS_OP_BEQ) || (op == `MIPS_OP_BNE);

   // logical immediates are zero extended, all others sign extended
   assign zero_ext = op inside {`MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI};
   assign imm      = zero_ext ? {16'h0000, imm_f} : {{16{imm_f[15]}}, imm_f};

   // r-type writes rd, i-type writes rt, jal writes ra
   assign reg_we = known && ((is_special && !is_jr && !is_syscall) ||
                             is_imm_alu || is_lw || is_jal);
   assign wr_idx = is_jal ? LINK_REG : (is_special ? rd : rt);
   assign wb_sel = is_lw ? WB_LOAD : (is_jal ? WB_LINK : WB_ALU);

   assign alu_use_imm = is_imm_alu || is_lw || is_sw;
   assign store       = is_sw;

   // next pc source, branch condition resolved in the pc unit
   assign pc_sel    = is_jr ? PC_REG : (is_jump ? PC_JUMP : (is_branch ? PC_BRANCH : PC_SEQ));
   assign branch_ne = (op == `MIPS_OP_BNE);

   // syscall or reserved instruction
   assign halt_req = !known || is_syscall;

endmodule

`default_nettype wire

// ==== design/mips_pc_unit.sv ====
//********************************************************************
// program counter and halt flag
// no delay slots, branch offsets are relative to pc+4
// the pc stays on the halting instruction and halted is sticky
// until reset
//********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module mips_pc_unit import mips_pkg::*; (
   input  logic        clk,
   input  logic        rst_b,
   input  pc_sel_e     pc_sel,
   input  logic        branch_ne,
   input  word_t       rs_data,
   input  word_t       rt_data,
   input  word_t       imm,
   input  logic [25:0] target,
   input  logic        halt_req,
   output word_t       pc,
   output word_t       pc_plus4,
   output logic        halted
);

   logic  taken;
   word_t br_target;
   word_t jmp_target;
   word_t next_pc;

   assign pc_plus4 = pc + 32'd4;

   // beq takes on equal, bne on not equal
   assign taken     = (rs_data == rt_data) != branch_ne;
   assign br_target = pc_plus4 + {imm[29:0], 2'b00};
   // region bits come from the current pc
   assign jmp_target = {pc[31:28], target, 2'b00};

   always_comb
   begin
      case (pc_sel)
         PC_BRANCH: next_pc = taken ? br_target : pc_plus4;
         PC_JUMP: next_pc = jmp_target;
         PC_REG: next_pc = rs_data;
         default: next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc     <= `MIPS_TEXT_START;
         halted <= 1'b0;
      end
      else
      begin
         // freeze on the halting instruction and everything after
         if (!halted && !halt_req)
         begin
            pc <= next_pc;
         end
         if (halt_req)
         begin
            halted <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/mips_pkg.sv ====
//********************************************************************
// types shared by the core and its bench
// enum encodings are internal and carry no meaning outside the core
//********************************************************************
`default_nettype none

package mips_pkg;

   // data word and byte address
   typedef logic [31:0] word_t;
   // register number, rs/rt/rd fields
   typedef logic [4:0] reg_idx_t;
   // byte address without its two low bits
   typedef logic [29:0] word_addr_t;
   // raw immediate field, inst[15:0]
   typedef logic [15:0] imm16_t;

   // alu operation chosen by the decoder
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } alu_op_e;

   // source of the next pc
   typedef enum logic [1:0] {
      PC_SEQ,
      PC_BRANCH,
      PC_JUMP,
      PC_REG
   } pc_sel_e;

   // source of the register write-back value
   typedef enum logic [1:0] {
      WB_ALU,
      WB_LOAD,
      WB_LINK
   } wb_sel_e;

endpackage

`default_nettype wire

// ==== design/mips_regfile.sv ====
//********************************************************************
// general register file, two async reads and one write per clock
// register 0 is never written and so always reads zero
//********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module mips_regfile import mips_pkg::*; (
   input  logic     clk,
   input  logic     rst_b,
   input  reg_idx_t rs_idx,
   input  reg_idx_t rt_idx,
   output word_t    rs_data,
   output word_t    rt_data,
   input  logic     we,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data
);

   word_t regs [`MIPS_NUM_REGS];

   // whole file clears on reset so register 0 starts at zero
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 0; i < `MIPS_NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      // writes to register 0 are dropped
      else if (we && (wr_idx != '0))
      begin
         regs[wr_idx] <= wr_data;
      end
   end

   // reads see the old value during a write cycle
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];

endmodule

`default_nettype wire

// ==== include/mips_params.svh ====
//********************************************************************
// shared constants of the reduced mips core
// reset pc follows the usual mips text segment base
// only the opcodes and funct codes of the kept instructions are listed
//********************************************************************
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// pc value while reset is held
`define MIPS_TEXT_START 32'h0040_0000
// general purpose registers, register 0 reads as zero
`define MIPS_NUM_REGS 32

// primary opcodes, inst[31:26]
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_J       6'h02
`define MIPS_OP_JAL     6'h03
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_SLTI    6'h0a
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b

// funct codes under the special opcode, inst[5:0]
`define MIPS_FN_SLL     6'h00
`define MIPS_FN_SRL     6'h02
`define MIPS_FN_SRA     6'h03
`define MIPS_FN_JR      6'h08
`define MIPS_FN_SYSCALL 6'h0c
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_NOR     6'h27
`define MIPS_FN_SLT     6'h2a

`endif

// ==== mips_lite.f ====
+incdir+include
design/mips_pkg.sv
design/mips_decode.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_pc_unit.sv
design/mips_core.sv
bench/mips_checker.sv
bench/tb_mips_core.sv
